/* Bender.yml */
package:
  name: mcs51_core

sources:
  # Core RTL, package first
  - files:
      - verilog/mcs51_pkg.sv
      - verilog/mcs51_fetch.sv
      - verilog/mcs51_decode.sv
      - verilog/mcs51_execute.sv
      - verilog/mcs51_data_mem.sv
      - verilog/mcs51_core.sv
  # Testbench, top module mcs51_tb
  - target: test
    files:
      - tb/mcs51_props.sv
      - tb/mcs51_tb.sv

/* flist.f */
verilog/mcs51_pkg.sv
verilog/mcs51_fetch.sv
verilog/mcs51_decode.sv
verilog/mcs51_execute.sv
verilog/mcs51_data_mem.sv
verilog/mcs51_core.sv
tb/mcs51_props.sv
tb/mcs51_tb.sv

/* tb/mcs51_props.sv */
// Rules are off during reset and ports that a bound module lacks are tied to their idle level
module mcs51_props (
	input logic clk,
	input logic sys_rst_n,
	input logic issue_i,
	input logic psen_n_i,
	input logic wr_valid_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned violations = 0;
	logic [1:0]  wr_cnt_q;

	// Writes seen since the last issue, saturating
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
			wr_cnt_q <= '0;
		else if (issue_i)
			wr_cnt_q <= '0;
		else if (wr_valid_i && (wr_cnt_q != 2'b11))
			wr_cnt_q <= wr_cnt_q + 1'b1;
	end

	// ------------------------------
	// Issue strobe
	// ------------------------------
	issue_one_cycle: assert property (@(posedge clk) disable iff (!sys_rst_n)
		issue_i |=> !issue_i)
	else
	begin
		$error("issue held for more than one cycle");
		violations++;
	end

	// Issue only lands in EXEC, with PSEN high
	issue_no_fetch: assert property (@(posedge clk) disable iff (!sys_rst_n)
		!(issue_i && !psen_n_i))
	else
	begin
		$error("issue seen during a fetch phase");
		violations++;
	end

	// At most one write per instruction
	write_once: assert property (@(posedge clk) disable iff (!sys_rst_n)
		wr_valid_i |-> (wr_cnt_q == 2'd0))
	else
	begin
		$error("second write request before the next issue");
		violations++;
	end

endmodule

/* tb/mcs51_stim.txt */
// Word 0 is the program length and word 1 the number of P1 values, in hex
// Then the program bytes in address order, then the expected P1 values in order
71
10
// MOV A,#imm and ANL, ORL, XRL, each copied to P1 by MOV 0x90,A
74 5A F5 90
54 0F F5 90
44 C0 F5 90
64 FF F5 90
// RL, RR twice, CPL, SWAP then NOP
23 F5 90
03 03 F5 90
F4 F5 90
C4 00 F5 90
// ADD then MOV A,0xD0 to show the flags
74 78 24 88 E5 D0 F5 90
74 46 24 3B E5 D0 F5 90
// R3 written in banks 1, 2 and 0
74 08 F5 D0 74 11 FB
74 10 F5 D0 74 22 FB
74 00 F5 D0 74 33 FB
// R3 read back per bank
74 08 F5 D0 EB F5 90
74 10 F5 D0 EB F5 90
74 00 F5 D0 EB F5 90
// Direct RAM reads, then bank 3 R7 seen at 0x1F
E5 0B F5 90
74 A5 F5 40 74 00 E5 40 F5 90
74 18 F5 D0 74 77 FF E5 1F F5 90
// Expected P1 sequence
5A 0A CA 35 6A 9A 65 56
C0 44
11 22 33 11 A5 77

/* tb/mcs51_tb.sv */
// Run from the project root for the stimulus path, and only fetch order and P1 changes are checked
module mcs51_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mcs51_pkg::*;

	localparam int unsigned SEED         = 10385;
	localparam string       STIM_FILE    = "tb/mcs51_stim.txt";
	localparam int          RAW_DEPTH    = 512;
	localparam int          CYC_PER_BYTE = 40;
	localparam int          CYC_MARGIN   = 100;
	localparam int          TAIL_CYCLES  = 60;

	logic        clk;
	logic        sys_rst_n;
	logic        ready_in_i;
	byte_t       mem_rdata_i;
	addr_t       mem_addr_o;
	logic        psen_n_o;
	byte_t       p1_o;

	byte_t       stim_raw [RAW_DEPTH];
	byte_t       prog_mem [256];
	byte_t       p1_exp [256];
	int          n_prog;
	int          n_exp;
	int          exp_idx;
	int          cycle_cnt;
	int          cycle_limit;
	int          tail_cnt;
	int          prop_fails;
	addr_t       next_addr;
	logic        in_take;
	byte_t       p1_last;
	int unsigned seed_ret;

	mcs51_core dut (
		.clk         (clk),
		.sys_rst_n   (sys_rst_n),
		.ready_in_i  (ready_in_i),
		.mem_rdata_i (mem_rdata_i),
		.mem_addr_o  (mem_addr_o),
		.psen_n_o    (psen_n_o),
		.p1_o        (p1_o)
	);

	// Fetch side has no write port, execute side has no PSEN
	bind mcs51_fetch mcs51_props fetch_props (
		.clk        (clk),
		.sys_rst_n  (sys_rst_n),
		.issue_i    (issue_o),
		.psen_n_i   (psen_n_o),
		.wr_valid_i (1'b0)
	);
	bind mcs51_execute mcs51_props exec_props (
		.clk        (clk),
		.sys_rst_n  (sys_rst_n),
		.issue_i    (issue_i),
		.psen_n_i   (1'b1),
		.wr_valid_i (wr_o.valid)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ------------------------------
	// Failure reporting
	// ------------------------------
	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic value_error(input string sig_name, input logic [15:0] expected,
		input logic [15:0] actual);
		$display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
			$time, sig_name, expected, actual);
		abort_run();
	endtask

	// Each P1 change must be the next value in the list
	task automatic check_p1();
		if (p1_o !== p1_last)
		begin
			assert (exp_idx < n_exp)
			else
			begin
				$display("P1 changed to 0x%0h after the last expected value", p1_o);
				abort_run();
			end
			assert (p1_o === p1_exp[exp_idx])
			else
				value_error("p1_o", p1_exp[exp_idx], p1_o);
			exp_idx++;
			p1_last = p1_o;
		end
	endtask

	initial
	begin
		sys_rst_n   = 1'b0;
		ready_in_i  = 1'b0;
		mem_rdata_i = '0;
		exp_idx     = 0;
		cycle_cnt   = 0;
		tail_cnt    = 0;
		prop_fails  = 0;
		next_addr   = '0;
		in_take     = 1'b0;
		p1_last     = '0;
		seed_ret    = $urandom(SEED);

		// Counts first, then program bytes, then expected P1 values
		$readmemh(STIM_FILE, stim_raw);
		assert (!$isunknown(stim_raw[0]) && !$isunknown(stim_raw[1])
			&& (stim_raw[0] != 0) && (stim_raw[1] != 0))
		else
		begin
			$display("Stimulus file %s is missing or holds no counts", STIM_FILE);
			abort_run();
		end
		n_prog = stim_raw[0];
		n_exp  = stim_raw[1];
		for (int i = 0; i < n_prog; i++)
			prog_mem[i] = stim_raw[2 + i];
		for (int i = 0; i < n_exp; i++)
			p1_exp[i] = stim_raw[2 + n_prog + i];
		cycle_limit = CYC_PER_BYTE * n_prog + CYC_MARGIN;

		// Two cycles of reset, released on a falling edge
		repeat (2) @(posedge clk);
		@(negedge clk);
		sys_rst_n = 1'b1;
		assert (psen_n_o === 1'b1) else value_error("psen_n_o", 1, psen_n_o);
		assert (p1_o === '0) else value_error("p1_o", 0, p1_o);

		// ------------------------------
		// Main loop, one pass per cycle
		// ------------------------------
		while ((exp_idx < n_exp) || (tail_cnt < TAIL_CYCLES))
		begin
			@(negedge clk);
			cycle_cnt++;
			if (cycle_cnt > cycle_limit)
			begin
				$display("Run timed out after %0d cycles with %0d of %0d P1 values seen",
					cycle_cnt, exp_idx, n_exp);
				abort_run();
			end
			// Timing rules in the bound checkers
			prop_fails = dut.u_fetch.fetch_props.violations
				+ dut.u_execute.exec_props.violations;
			assert (prop_fails == 0)
			else
			begin
				$display("Bound timing rules failed %0d times", prop_fails);
				abort_run();
			end
			// First opcode fetch from address zero
			if (cycle_cnt == 1)
			begin
				assert (psen_n_o === 1'b0) else value_error("psen_n_o", 0, psen_n_o);
				assert (mem_addr_o === '0) else value_error("mem_addr_o", 0, mem_addr_o);
			end
			check_p1();
			// Quiet window after the last value catches extra writes
			if (exp_idx == n_exp)
				tail_cnt++;

			ready_in_i = (($urandom() % 4) != 0);
			// Past the loaded program reads as NOP
			if (int'(mem_addr_o) < n_prog)
				mem_rdata_i = prog_mem[mem_addr_o[7:0]];
			else
				mem_rdata_i = 8'h00;

			// WAIT with ready high takes a byte, the TAKE cycle after it does not
			if (in_take)
				in_take = 1'b0;
			else if (!psen_n_o && ready_in_i)
			begin
				assert (mem_addr_o === next_addr)
				else
					value_error("mem_addr_o", next_addr, mem_addr_o);
				next_addr = next_addr + 1'b1;
				in_take   = 1'b1;
			end
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verilog/mcs51_core.sv */
// Top of the subset core with program memory outside and P1 as the only data output
module mcs51_core (
	input  logic             clk,
	input  logic             sys_rst_n,
	input  logic             ready_in_i,
	input  mcs51_pkg::byte_t mem_rdata_i,
	output mcs51_pkg::addr_t mem_addr_o,
	output logic             psen_n_o,
	output mcs51_pkg::byte_t p1_o
);
	import mcs51_pkg::*;

	opcode_u opcode;
	ctrl_t   ctrl;
	instr_t  instr;
	logic    issue;
	byte_t   rd_addr;
	byte_t   rd_data;
	byte_t   psw;
	wr_req_t wr_req;

	// Fetch and decode
	mcs51_fetch u_fetch (
		.clk         (clk),
		.sys_rst_n   (sys_rst_n),
		.ready_in_i  (ready_in_i),
		.mem_rdata_i (mem_rdata_i),
		.two_byte_i  (ctrl.two_byte),
		.mem_addr_o  (mem_addr_o),
		.psen_n_o    (psen_n_o),
		.opcode_o    (opcode),
		.instr_o     (instr),
		.issue_o     (issue)
	);

	mcs51_decode u_decode (
		.opcode_i (opcode),
		.ctrl_o   (ctrl)
	);

	// Execute and data memory
	mcs51_execute u_execute (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.issue_i   (issue),
		.instr_i   (instr),
		.ctrl_i    (ctrl),
		.rd_data_i (rd_data),
		.rd_addr_o (rd_addr),
		.psw_o     (psw),
		.wr_o      (wr_req)
	);

	mcs51_data_mem u_data_mem (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.rd_addr_i (rd_addr),
		.psw_i     (psw),
		.wr_i      (wr_req),
		.rd_data_o (rd_data),
		.p1_o      (p1_o)
	);

endmodule

/* verilog/mcs51_data_mem.sv */
// Holds the lower 128 bytes and P1 only, and SFRs other than P1 and PSW read as zero and drop writes
module mcs51_data_mem (
	input  logic               clk,
	input  logic               sys_rst_n,
	input  mcs51_pkg::byte_t   rd_addr_i,
	input  mcs51_pkg::byte_t   psw_i,
	input  mcs51_pkg::wr_req_t wr_i,
	output mcs51_pkg::byte_t   rd_data_o,
	output mcs51_pkg::byte_t   p1_o
);
	import mcs51_pkg::*;

	typedef enum logic [1:0] {RG_RAM, RG_P1, RG_PSW, RG_NONE} region_e;

	byte_t   iram [IRAM_DEPTH];
	byte_t   p1_q;
	region_e rd_region;
	region_e wr_region;

	// Bit 7 clear means internal RAM, set means SFR space
	function automatic region_e region_of(byte_t addr);
		region_e r;
		if (!addr[DATA_W-1])
			r = RG_RAM;
		else if (addr == SFR_P1)
			r = RG_P1;
		else if (addr == SFR_PSW)
			r = RG_PSW;
		else
			r = RG_NONE;
		return r;
	endfunction

	assign rd_region = region_of(rd_addr_i);
	assign wr_region = region_of(wr_i.addr);

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb
	begin
		case (rd_region)
			RG_RAM:  rd_data_o = iram[rd_addr_i[IRAM_ADDR_W-1:0]];
			RG_P1:   rd_data_o = p1_q;
			// PSW register sits in execute
			RG_PSW:  rd_data_o = psw_i;
			default: rd_data_o = '0;
		endcase
	end

	// ------------------------------
	// Write port
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			p1_q <= '0;
			for (int i = 0; i < IRAM_DEPTH; i++)
				iram[i] <= '0;
		end
		else if (wr_i.valid)
		begin
			case (wr_region)
				RG_RAM:
					iram[wr_i.addr[IRAM_ADDR_W-1:0]] <= wr_i.data;
				RG_P1:
					p1_q <= wr_i.data;
				// PSW writes are taken by execute
				default:
					p1_q <= p1_q;
			endcase
		end
	end

	assign p1_o = p1_q;

endmodule

/* verilog/mcs51_decode.sv */
// Covers only the kept MOV, logic, rotate and ADD opcodes and any other byte runs as NOP
module mcs51_decode (
	input  mcs51_pkg::opcode_u opcode_i,
	output mcs51_pkg::ctrl_t   ctrl_o
);
	import mcs51_pkg::*;

	// ------------------------------
	// Datapath routing
	// ------------------------------
	always_comb
	begin
		// NOP shape by default
		ctrl_o.two_byte       = 1'b0;
		ctrl_o.src            = SRC_ACC;
		ctrl_o.dst            = DST_NONE;
		ctrl_o.alu_op         = ALU_PASS;
		ctrl_o.flag_update    = 1'b0;
		ctrl_o.mem_addr.is_rn = 1'b0;
		ctrl_o.mem_addr.addr  = '0;

		// Full bytes first
		case (opcode_i.byte_v)
			OP_MOV_A_IMM, OP_ADD_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM:
			begin
				ctrl_o.two_byte = 1'b1;
				ctrl_o.src      = SRC_IMM;
				ctrl_o.dst      = DST_ACC;
			end
			// Direct address follows in the operand byte
			OP_MOV_A_DIR:
			begin
				ctrl_o.two_byte = 1'b1;
				ctrl_o.src      = SRC_DIR;
				ctrl_o.dst      = DST_ACC;
			end
			OP_MOV_DIR_A:
			begin
				ctrl_o.two_byte = 1'b1;
				ctrl_o.dst      = DST_MEM;
			end
			// Accumulator only
			OP_RL_A, OP_RR_A, OP_CPL_A, OP_SWAP_A:
				ctrl_o.dst = DST_ACC;
			OP_NOP:
				ctrl_o.dst = DST_NONE;
			// Then the Rn prefixes
			default:
				case (opcode_i.rn_v.prefix)
					OP_MOV_A_RN:
					begin
						ctrl_o.src            = SRC_REG;
						ctrl_o.dst            = DST_ACC;
						ctrl_o.mem_addr.is_rn = 1'b1;
						ctrl_o.mem_addr.addr  = DATA_W'(opcode_i.rn_v.rn);
					end
					OP_MOV_RN_A:
					begin
						ctrl_o.dst            = DST_MEM;
						ctrl_o.mem_addr.is_rn = 1'b1;
						ctrl_o.mem_addr.addr  = DATA_W'(opcode_i.rn_v.rn);
					end
					default:
						ctrl_o.dst = DST_NONE;
				endcase
		endcase

		// ------------------------------
		// ALU operation
		// ------------------------------
		case (opcode_i.byte_v)
			// Only ADD touches CY, AC and OV
			OP_ADD_IMM:
			begin
				ctrl_o.alu_op      = ALU_ADD;
				ctrl_o.flag_update = 1'b1;
			end
			OP_ANL_IMM:
				ctrl_o.alu_op = ALU_AND;
			OP_ORL_IMM:
				ctrl_o.alu_op = ALU_OR;
			OP_XRL_IMM:
				ctrl_o.alu_op = ALU_XOR;
			OP_RL_A:
				ctrl_o.alu_op = ALU_RL;
			OP_RR_A:
				ctrl_o.alu_op = ALU_RR;
			OP_CPL_A:
				ctrl_o.alu_op = ALU_CPL;
			OP_SWAP_A:
				ctrl_o.alu_op = ALU_SWAP;
			default:
				ctrl_o.alu_op = ALU_PASS;
		endcase
	end

endmodule

/* verilog/mcs51_execute.sv */
// Expects issue_i only while idle and a direct address of 0xD0 as destination always writes the PSW
module mcs51_execute (
	input  logic               clk,
	input  logic               sys_rst_n,
	input  logic               issue_i,
	input  mcs51_pkg::instr_t  instr_i,
	input  mcs51_pkg::ctrl_t   ctrl_i,
	input  mcs51_pkg::byte_t   rd_data_i,
	output mcs51_pkg::byte_t   rd_addr_o,
	output mcs51_pkg::byte_t   psw_o,
	output mcs51_pkg::wr_req_t wr_o
);
	import mcs51_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_ALU, ST_WRITE} step_e;

	step_e               step_q;
	ctrl_t               ctrl_q;
	ctrl_t               ctrl_l;
	byte_t               imm_q;
	byte_t               acc_q;
	logic [DATA_W-1:1]   psw_q;
	byte_t               opnd_d;
	byte_t               opnd_q;
	byte_t               alu_res;
	logic [3:0]          sum_lo;
	logic [2:0]          sum_mid;
	logic                sum_hi;
	logic                c3;
	logic                c6;
	logic                cy;
	logic                wr_valid_q;
	byte_t               wr_addr_q;
	byte_t               wr_data_q;

	// Direct forms take their address from the operand byte
	always_comb
	begin
		ctrl_l = ctrl_i;
		if (!ctrl_i.mem_addr.is_rn)
			ctrl_l.mem_addr.addr = instr_i.operand;
		if ((ctrl_i.dst == DST_MEM) && !ctrl_i.mem_addr.is_rn && (instr_i.operand == SFR_PSW))
			ctrl_l.dst = DST_PSW;
	end

	// Bank select lives here only, RS times 8 plus n
	assign rd_addr_o = ctrl_q.mem_addr.is_rn ?
		{{(DATA_W-RN_W-2){1'b0}}, psw_q[PSW_RS1:PSW_RS0], ctrl_q.mem_addr.addr[RN_W-1:0]} :
		ctrl_q.mem_addr.addr;

	always_comb
	begin
		case (ctrl_q.src)
			SRC_IMM: opnd_d = imm_q;
			SRC_ACC: opnd_d = acc_q;
			default: opnd_d = rd_data_i;
		endcase
	end

	// ------------------------------
	// ALU
	// ------------------------------
	always_comb
	begin
		// Nibble-split add, no carry in
		{c3, sum_lo}  = acc_q[3:0] + opnd_q[3:0];
		{c6, sum_mid} = acc_q[6:4] + opnd_q[6:4] + c3;
		{cy, sum_hi}  = acc_q[7] + opnd_q[7] + c6;
		case (ctrl_q.alu_op)
			ALU_ADD:  alu_res = {sum_hi, sum_mid, sum_lo};
			ALU_AND:  alu_res = acc_q & opnd_q;
			ALU_OR:   alu_res = acc_q | opnd_q;
			ALU_XOR:  alu_res = acc_q ^ opnd_q;
			// Unary ops act on the operand, which is A for these opcodes
			ALU_RL:   alu_res = {opnd_q[6:0], opnd_q[7]};
			ALU_RR:   alu_res = {opnd_q[0], opnd_q[7:1]};
			ALU_CPL:  alu_res = ~opnd_q;
			ALU_SWAP: alu_res = {opnd_q[3:0], opnd_q[7:4]};
			default:  alu_res = opnd_q;
		endcase
	end

	// ------------------------------
	// Step sequence after issue
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			step_q     <= ST_IDLE;
			ctrl_q     <= '0;
			acc_q      <= '0;
			psw_q      <= '0;
			wr_valid_q <= 1'b0;
		end
		else
		begin
			wr_valid_q <= 1'b0;
			case (step_q)
				ST_IDLE:
					if (issue_i)
					begin
						ctrl_q <= ctrl_l;
						step_q <= ST_READ;
					end
				ST_READ:
					step_q <= ST_ALU;
				ST_ALU:
				begin
					step_q <= ST_WRITE;
					if (ctrl_q.dst == DST_ACC)
						acc_q <= alu_res;
					if (ctrl_q.dst == DST_PSW)
						psw_q <= alu_res[DATA_W-1:1];
					if (ctrl_q.flag_update)
					begin
						psw_q[PSW_CY] <= cy;
						psw_q[PSW_AC] <= c3;
						psw_q[PSW_OV] <= cy ^ c6;
					end
					// Request shows during the WRITE step
					wr_valid_q <= (ctrl_q.dst == DST_MEM);
				end
				default:
					step_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue_i)
			imm_q <= instr_i.operand;
		if (step_q == ST_READ)
			opnd_q <= opnd_d;
		if (step_q == ST_ALU)
		begin
			wr_addr_q <= rd_addr_o;
			wr_data_q <= alu_res;
		end
	end

	// P tracks the accumulator at all times
	assign psw_o      = {psw_q, ^acc_q};
	assign wr_o.valid = wr_valid_q;
	assign wr_o.addr  = wr_addr_q;
	assign wr_o.data  = wr_data_q;

endmodule

/* verilog/mcs51_fetch.sv */
// Fetches in address order only since there are no jumps, and ready_in_i must rise for each WAIT phase to end
module mcs51_fetch (
	input  logic               clk,
	input  logic               sys_rst_n,
	input  logic               ready_in_i,
	input  mcs51_pkg::byte_t   mem_rdata_i,
	input  logic               two_byte_i,
	output mcs51_pkg::addr_t   mem_addr_o,
	output logic               psen_n_o,
	output mcs51_pkg::opcode_u opcode_o,
	output mcs51_pkg::instr_t  instr_o,
	output logic               issue_o
);
	import mcs51_pkg::*;

	typedef enum logic [2:0] {
		PH_IDLE, PH_OP_WAIT, PH_OP_TAKE, PH_ARG_WAIT, PH_ARG_TAKE, PH_EXEC
	} phase_e;

	phase_e                phase_q;
	phase_e                phase_d;
	addr_t                 pc_q;
	opcode_u               opcode_q;
	byte_t                 operand_q;
	logic [EXEC_CNT_W-1:0] exec_cnt_q;
	logic                  issue_q;
	logic                  take;
	logic                  last_take;

	// ------------------------------
	// Phase sequencer
	// ------------------------------
	assign take      = (phase_q == PH_OP_TAKE) || (phase_q == PH_ARG_TAKE);
	// Opcode TAKE is last only for one-byte instructions
	assign last_take = ((phase_q == PH_OP_TAKE) && !two_byte_i) || (phase_q == PH_ARG_TAKE);

	always_comb
	begin
		phase_d = phase_q;
		case (phase_q)
			PH_IDLE:
				phase_d = PH_OP_WAIT;
			PH_OP_WAIT:
				if (ready_in_i)
					phase_d = PH_OP_TAKE;
			// Decode answers two_byte_i from the opcode just taken
			PH_OP_TAKE:
				phase_d = two_byte_i ? PH_ARG_WAIT : PH_EXEC;
			PH_ARG_WAIT:
				if (ready_in_i)
					phase_d = PH_ARG_TAKE;
			PH_ARG_TAKE:
				phase_d = PH_EXEC;
			// Fixed window, never stretched by ready_in_i
			PH_EXEC:
				if (exec_cnt_q == EXEC_CNT_W'(EXEC_CYCLES - 1))
					phase_d = PH_OP_WAIT;
			default:
				phase_d = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			phase_q    <= PH_IDLE;
			pc_q       <= '0;
			exec_cnt_q <= '0;
			issue_q    <= 1'b0;
		end
		else
		begin
			phase_q <= phase_d;
			// Strobe lands in the first EXEC cycle
			issue_q <= last_take;
			if (take)
				pc_q <= pc_q + 1'b1;
			if (phase_q == PH_EXEC)
				exec_cnt_q <= exec_cnt_q + 1'b1;
			else
				exec_cnt_q <= '0;
		end
	end

	// Bytes are taken on the edge that ends a WAIT phase
	always_ff @(posedge clk)
	begin
		if ((phase_q == PH_OP_WAIT) && ready_in_i)
			opcode_q.byte_v <= mem_rdata_i;
		if ((phase_q == PH_ARG_WAIT) && ready_in_i)
			operand_q <= mem_rdata_i;
	end

	assign mem_addr_o      = pc_q;
	assign psen_n_o        = !((phase_q == PH_OP_WAIT) || (phase_q == PH_ARG_WAIT) || take);
	assign opcode_o        = opcode_q;
	assign instr_o.opcode  = opcode_q;
	assign instr_o.operand = operand_q;
	assign issue_o         = issue_q;

endmodule

/* verilog/mcs51_pkg.sv */
// Widths are fixed by the MCS-51 architecture and only the kept instruction subset has opcodes here
package mcs51_pkg;

	// ------------------------------
	// Widths and sizes
	// ------------------------------
	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;
	localparam int RN_W        = 3;
	localparam int IRAM_DEPTH  = 128;
	localparam int IRAM_ADDR_W = $clog2(IRAM_DEPTH);
	localparam int EXEC_CYCLES = 6;
	localparam int EXEC_CNT_W  = $clog2(EXEC_CYCLES);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;

	// SFR map, only P1 and PSW exist
	localparam byte_t SFR_P1  = 8'h90;
	localparam byte_t SFR_PSW = 8'hD0;

	// PSW bit positions, P is bit 0
	localparam int PSW_CY  = 7;
	localparam int PSW_AC  = 6;
	localparam int PSW_RS1 = 4;
	localparam int PSW_RS0 = 3;
	localparam int PSW_OV  = 2;

	// ------------------------------
	// Opcodes
	// ------------------------------
	localparam byte_t OP_NOP       = 8'h00;
	localparam byte_t OP_RR_A      = 8'h03;
	localparam byte_t OP_RL_A      = 8'h23;
	localparam byte_t OP_ADD_IMM   = 8'h24;
	localparam byte_t OP_ORL_IMM   = 8'h44;
	localparam byte_t OP_ANL_IMM   = 8'h54;
	localparam byte_t OP_XRL_IMM   = 8'h64;
	localparam byte_t OP_MOV_A_IMM = 8'h74;
	localparam byte_t OP_SWAP_A    = 8'hC4;
	localparam byte_t OP_MOV_A_DIR = 8'hE5;
	localparam byte_t OP_CPL_A     = 8'hF4;
	localparam byte_t OP_MOV_DIR_A = 8'hF5;
	// Rn forms, low 3 bits pick the register
	localparam logic [DATA_W-RN_W-1:0] OP_MOV_A_RN = 5'b11101;
	localparam logic [DATA_W-RN_W-1:0] OP_MOV_RN_A = 5'b11111;

	// Opcode byte, whole or split into prefix and register index
	typedef union packed {
		byte_t byte_v;
		struct packed {
			logic [DATA_W-RN_W-1:0] prefix;
			logic [RN_W-1:0]        rn;
		} rn_v;
	} opcode_u;

	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR,
		ALU_RL, ALU_RR, ALU_CPL, ALU_SWAP
	} alu_op_e;

	typedef enum logic [1:0] {SRC_IMM, SRC_DIR, SRC_REG, SRC_ACC} src_e;
	typedef enum logic [1:0] {DST_NONE, DST_ACC, DST_PSW, DST_MEM} dst_e;

	typedef struct packed {
		opcode_u opcode;
		byte_t   operand;
	} instr_t;

	// Direct address, or register index when is_rn is set
	typedef struct packed {
		logic  is_rn;
		byte_t addr;
	} mem_sel_t;

	typedef struct packed {
		logic     two_byte;
		src_e     src;
		dst_e     dst;
		alu_op_e  alu_op;
		logic     flag_update;
		mem_sel_t mem_addr;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		byte_t addr;
		byte_t data;
	} wr_req_t;

endpackage
